// File: Makefile
SRCS = fifo_pkg.sv srl_shift_column.sv srl_fifo.sv ring_fifo.sv \
       fifo_mover.sv fifo_chain_top.sv tb_fifo_chain.sv

.PHONY: all run lint clean

all: run

obj_dir/Vtb_fifo_chain: sim.f $(SRCS)
	verilator --binary --timing --assert -j 0 --top-module tb_fifo_chain -f sim.f

run: obj_dir/Vtb_fifo_chain
	./obj_dir/Vtb_fifo_chain | tee sim.log
	@if grep -q "Simulation finished: PASS" sim.log; then \
		echo "run passed"; \
	else \
		echo "run failed"; \
		exit 1; \
	fi

lint:
	verilator --lint-only -Wall --timing --top-module tb_fifo_chain -f sim.f
	verilator --lint-only -Wall --top-module fifo_chain_top fifo_pkg.sv \
		srl_shift_column.sv srl_fifo.sv ring_fifo.sv fifo_mover.sv fifo_chain_top.sv

clean:
	rm -rf obj_dir sim.log

// File: fifo_chain_top.sv
`timescale 1ns/1ps

// input SRL FIFO -> mover -> output ring
module fifo_chain_top (
  input  logic                i_clk,
  input  logic                i_rst_n,
  input  logic                i_clr_err,
  input  logic                i_enq,
  input  fifo_pkg::word_t     i_data,
  input  logic                i_read,
  output fifo_pkg::word_t     o_item,
  output logic                o_empty,
  output logic                o_full,
  output logic                o_available,
  output logic                o_overrun,
  output logic                o_underrun,
  output fifo_pkg::move_cnt_t o_moved
);
  import fifo_pkg::*;

  word_t src_data;
  logic  src_empty;
  logic  src_deq;
  xfer_t xfer;
  logic  ring_full;   // internal only, back-pressure to the mover

  srl_fifo u_srl_fifo (
    .i_clk       (i_clk),
    .i_rst_n     (i_rst_n),
    .i_clr_err   (i_clr_err),
    .i_enq       (i_enq),
    .i_data      (i_data),
    .i_deq       (src_deq),
    .o_data      (src_data),
    .o_empty     (src_empty),
    .o_full      (o_full),
    .o_available (o_available),
    .o_overrun   (o_overrun)
  );

  fifo_mover u_fifo_mover (
    .i_clk       (i_clk),
    .i_rst_n     (i_rst_n),
    .i_src_data  (src_data),
    .i_src_empty (src_empty),
    .o_src_deq   (src_deq),
    .i_dst_full  (ring_full),
    .o_xfer      (xfer),
    .o_moved     (o_moved)
  );

  ring_fifo u_ring_fifo (
    .i_clk      (i_clk),
    .i_rst_n    (i_rst_n),
    .i_clr_err  (i_clr_err),
    .i_xfer     (xfer),
    .i_read     (i_read),
    .o_item     (o_item),
    .o_empty    (o_empty),
    .o_full     (ring_full),
    .o_underrun (o_underrun)
  );

endmodule

// File: fifo_mover.sv
`timescale 1ns/1ps

// single-word stage pulling from the input FIFO and writing the ring
module fifo_mover (
  input  logic                i_clk,
  input  logic                i_rst_n,
  input  fifo_pkg::word_t     i_src_data,
  input  logic                i_src_empty,
  output logic                o_src_deq,
  input  logic                i_dst_full,
  output fifo_pkg::xfer_t     o_xfer,
  output fifo_pkg::move_cnt_t o_moved
);
  import fifo_pkg::*;

  logic      valid_q;
  word_t     data_q;
  logic      write_out;
  logic      can_load;
  move_cnt_t moved_q;

  assign write_out = valid_q && !i_dst_full;     // ring flag is registered
  assign can_load  = !valid_q || write_out;      // empty or emptying now
  assign o_src_deq = can_load && !i_src_empty;

  always_ff @(posedge i_clk or negedge i_rst_n) begin
    if (!i_rst_n) begin
      valid_q <= 1'b0;
    end else if (o_src_deq) begin
      valid_q <= 1'b1;
    end else if (write_out) begin
      valid_q <= 1'b0;
    end
  end

  always_ff @(posedge i_clk) begin
    if (o_src_deq) begin
      data_q <= i_src_data; // head captured at the dequeue edge
    end
  end

  always_ff @(posedge i_clk or negedge i_rst_n) begin
    if (!i_rst_n) begin
      moved_q <= '0;
    end else if (write_out) begin
      moved_q <= moved_q + 1'b1; // wraps at 16 bits
    end
  end

  assign o_xfer.valid = write_out;
  assign o_xfer.data  = data_q;
  assign o_moved      = moved_q;

  // the ring only fills through this port so its registered full flag stays current
  a_full_from_write: assert property (
    @(posedge i_clk) disable iff (!i_rst_n)
    (!i_dst_full && !o_xfer.valid) |=> !i_dst_full
  ) else $error("fifo_mover: ring went full without a write");

endmodule

// File: fifo_pkg.sv
package fifo_pkg;

  // datapath word
  localparam int WORD_W = 128;
  typedef logic [WORD_W-1:0] word_t;

  // input FIFO, one shift column per data bit
  localparam int SRL_DEPTH = 32;
  typedef logic [$clog2(SRL_DEPTH+1)-1:0] srl_cnt_t;  // 0 .. SRL_DEPTH
  typedef logic [$clog2(SRL_DEPTH)-1:0]   srl_addr_t; // tap select

  // fill thresholds seen by upstream
  localparam srl_cnt_t SRL_FULL_LEVEL  = srl_cnt_t'(29); // three entries of slack
  localparam srl_cnt_t SRL_AVAIL_LEVEL = srl_cnt_t'(8);

  // output ring
  localparam int RING_DEPTH_LOG2 = 4;
  localparam int RING_DEPTH      = 1 << RING_DEPTH_LOG2;
  typedef logic [RING_DEPTH_LOG2-1:0] ring_ptr_t;

  // words moved, wraps
  typedef logic [15:0] move_cnt_t;

  // mover -> ring write port, valid doubles as write strobe
  typedef struct packed {
    logic  valid;
    word_t data;
  } xfer_t;

endpackage

// File: ring_fifo.sv
`timescale 1ns/1ps

// circular output FIFO with show-ahead read and registered empty/full
module ring_fifo (
  input  logic            i_clk,
  input  logic            i_rst_n,
  input  logic            i_clr_err,
  input  fifo_pkg::xfer_t i_xfer,
  input  logic            i_read,
  output fifo_pkg::word_t o_item,
  output logic            o_empty,
  output logic            o_full,
  output logic            o_underrun
);
  import fifo_pkg::*;

  word_t     mem [RING_DEPTH];
  ring_ptr_t wr_ptr;
  ring_ptr_t rd_ptr;
  ring_ptr_t wr_next;
  ring_ptr_t rd_next;
  logic      empty_q;
  logic      full_q;
  logic      underrun_q;
  logic      wr_ok;
  logic      rd_ok;

  assign wr_next = wr_ptr + 1'b1; // wraps at RING_DEPTH
  assign rd_next = rd_ptr + 1'b1;

  // a read in the same cycle frees a slot for a write into a full ring
  assign rd_ok = i_read && !empty_q;
  assign wr_ok = i_xfer.valid && (!full_q || rd_ok);

  always_ff @(posedge i_clk) begin
    if (wr_ok) begin
      mem[wr_ptr] <= i_xfer.data;
    end
  end

  assign o_item = mem[rd_ptr]; // head word while not empty

  always_ff @(posedge i_clk or negedge i_rst_n) begin
    if (!i_rst_n) begin
      wr_ptr <= '0;
      rd_ptr <= '0;
    end else begin
      if (wr_ok) begin
        wr_ptr <= wr_next;
      end
      if (rd_ok) begin
        rd_ptr <= rd_next;
      end
    end
  end

  // flags move with the pointers
  always_ff @(posedge i_clk or negedge i_rst_n) begin
    if (!i_rst_n) begin
      empty_q <= 1'b1;
      full_q  <= 1'b0;
    end else begin
      case ({wr_ok, rd_ok})
        2'b01: begin   // read only
          full_q  <= 1'b0;
          empty_q <= (rd_next == wr_ptr);
        end
        2'b10: begin   // write only
          empty_q <= 1'b0;
          full_q  <= (wr_next == rd_ptr);
        end
        2'b11: begin   // both at once keep the fill level
          empty_q <= 1'b0;
          full_q  <= full_q;
        end
        default: begin
          empty_q <= empty_q;
          full_q  <= full_q;
        end
      endcase
    end
  end

  // a read on empty moves no pointer and only raises this flag
  always_ff @(posedge i_clk or negedge i_rst_n) begin
    if (!i_rst_n) begin
      underrun_q <= 1'b0;
    end else if (i_clr_err) begin
      underrun_q <= 1'b0;
    end else if (i_read && empty_q) begin
      underrun_q <= 1'b1;
    end
  end

  assign o_empty    = empty_q;
  assign o_full     = full_q;
  assign o_underrun = underrun_q;

  a_flags_exclusive: assert property (
    @(posedge i_clk) disable iff (!i_rst_n)
    !(empty_q && full_q)
  ) else $error("ring_fifo: empty and full together");

endmodule

// File: sim.f
fifo_pkg.sv
srl_shift_column.sv
srl_fifo.sv
ring_fifo.sv
fifo_mover.sv
fifo_chain_top.sv
tb_fifo_chain.sv

// File: srl_fifo.sv
`timescale 1ns/1ps

// input FIFO built from shift columns; oldest word sits at tap count-1
module srl_fifo (
  input  logic            i_clk,
  input  logic            i_rst_n,
  input  logic            i_clr_err,
  input  logic            i_enq,
  input  fifo_pkg::word_t i_data,
  input  logic            i_deq,
  output fifo_pkg::word_t o_data,
  output logic            o_empty,
  output logic            o_full,
  output logic            o_available,
  output logic            o_overrun
);
  import fifo_pkg::*;

  srl_cnt_t  count;
  srl_addr_t tap_addr;
  logic      at_depth;   // all SRL_DEPTH entries in use
  logic      enq_ok;
  logic      deq_ok;
  logic      overrun_q;

  assign at_depth = (count == srl_cnt_t'(SRL_DEPTH));
  assign enq_ok   = i_enq && !at_depth; // word past depth is dropped
  assign deq_ok   = i_deq && !o_empty;

  // head lives one below the fill count
  assign tap_addr = srl_addr_t'(count - srl_cnt_t'(1));

  // levels straight from the count
  assign o_empty     = (count == '0);
  assign o_full      = (count >= SRL_FULL_LEVEL);
  assign o_available = (count <= SRL_AVAIL_LEVEL);
  assign o_overrun   = overrun_q;

  always_ff @(posedge i_clk or negedge i_rst_n) begin
    if (!i_rst_n) begin
      count <= '0;
    end else begin
      count <= count + srl_cnt_t'(enq_ok) - srl_cnt_t'(deq_ok); // enq+deq keeps it
    end
  end

  // sticky, only reset or clr_err bring it down
  always_ff @(posedge i_clk or negedge i_rst_n) begin
    if (!i_rst_n) begin
      overrun_q <= 1'b0;
    end else if (i_clr_err) begin
      overrun_q <= 1'b0;
    end else if (i_enq && at_depth) begin
      overrun_q <= 1'b1;
    end
  end

  // one column per data bit, all sharing enable and tap
  for (genvar gi = 0; gi < WORD_W; gi++) begin : g_col
    srl_shift_column u_col (
      .i_clk  (i_clk),
      .i_en   (enq_ok),
      .i_d    (i_data[gi]),
      .i_addr (tap_addr),
      .o_q    (o_data[gi])
    );
  end

  // reader must watch o_empty
  a_no_deq_empty: assert property (
    @(posedge i_clk) disable iff (!i_rst_n)
    i_deq |-> !o_empty
  ) else $error("srl_fifo: dequeue while empty");

endmodule

// File: srl_shift_column.sv
`timescale 1ns/1ps

// one bit column of the input FIFO, behaves like an addressable SRL
module srl_shift_column (
  input  logic                i_clk,
  input  logic                i_en,
  input  logic                i_d,
  input  fifo_pkg::srl_addr_t i_addr,
  output logic                o_q
);
  import fifo_pkg::*;

  logic [SRL_DEPTH-1:0] taps; // no reset, as in the primitive

  // new bit enters at tap 0, older bits move up
  always_ff @(posedge i_clk) begin
    if (i_en) begin
      taps <= {taps[SRL_DEPTH-2:0], i_d};
    end
  end

  assign o_q = taps[i_addr]; // async tap read

endmodule

// File: tb_fifo_chain.sv
`timescale 1ns/1ps

module tb_fifo_chain;
  import fifo_pkg::*;

  localparam int CLK_PERIOD  = 10;
  localparam int DRIVE_DLY   = 1;
  localparam int RST_CYCLES  = 10;
  localparam int RAND_CYCLES = 400;
  localparam int BP_CYCLES   = 300;
  localparam int CHAIN_CAP   = RING_DEPTH + 1 + SRL_DEPTH;       // ring, mover, input FIFO
  localparam int LVL_WORDS   = RING_DEPTH + 1 + int'(SRL_FULL_LEVEL);
  // drains and settling gaps get a flat allowance
  localparam int PLANNED_CYCLES = RST_CYCLES + RAND_CYCLES + BP_CYCLES
                                + 5 * LVL_WORDS + 3 * CHAIN_CAP + 200;

  logic      i_clk;
  logic      i_rst_n;
  logic      i_clr_err;
  logic      i_enq;
  word_t     i_data;
  logic      i_read;
  word_t     o_item;
  logic      o_empty;
  logic      o_full;
  logic      o_available;
  logic      o_overrun;
  logic      o_underrun;
  move_cnt_t o_moved;

  // expectations, set just after an edge and checked at the next one
  logic      chk_item;
  word_t     exp_item;
  logic      chk_lvl;
  logic      exp_avail;
  logic      exp_full;
  logic      chk_moved;
  move_cnt_t exp_moved;
  logic      chk_rst;
  logic      drop_enq;   // enqueue that the input FIFO must discard

  word_t model_q[$];     // words in flight, oldest first
  int    seed = 32'h23d0_db91;
  int    pushed;
  int    err_cnt;
  int    test_err_base;
  int    pass_cnt;
  int    fail_cnt;

  fifo_chain_top fifo_chain_top_inst (
    .i_clk       (i_clk),
    .i_rst_n     (i_rst_n),
    .i_clr_err   (i_clr_err),
    .i_enq       (i_enq),
    .i_data      (i_data),
    .i_read      (i_read),
    .o_item      (o_item),
    .o_empty     (o_empty),
    .o_full      (o_full),
    .o_available (o_available),
    .o_overrun   (o_overrun),
    .o_underrun  (o_underrun),
    .o_moved     (o_moved)
  );

  initial begin
    i_clk = 1'b0;
    forever #(CLK_PERIOD / 2) i_clk = ~i_clk;
  end

  initial begin
    #(PLANNED_CYCLES * 20 * CLK_PERIOD);
    $display("timeout: run still busy after %0d cycles", PLANNED_CYCLES * 20);
    $display("Simulation finished: FAIL");
    $finish;
  end

  function automatic void log_mismatch(input string what);
    err_cnt++;
    $display("Mismatch at %0t ns: %s", $time, what);
  endfunction

  function automatic void log_failure(input string what);
    err_cnt++;
    $display("error at %0t ns: %s", $time, what);
  endfunction

  a_item: assert property (@(posedge i_clk) disable iff (!i_rst_n)
    chk_item |-> (o_item == exp_item))
    else log_mismatch($sformatf("o_item %h, expected %h", $sampled(o_item), $sampled(exp_item)));

  a_levels: assert property (@(posedge i_clk) disable iff (!i_rst_n)
    chk_lvl |-> (o_available == exp_avail && o_full == exp_full))
    else log_mismatch($sformatf("o_available %b o_full %b, expected %b %b",
      $sampled(o_available), $sampled(o_full), $sampled(exp_avail), $sampled(exp_full)));

  a_moved: assert property (@(posedge i_clk) disable iff (!i_rst_n)
    chk_moved |-> (o_moved == exp_moved))
    else log_mismatch($sformatf("o_moved %0d, expected %0d", $sampled(o_moved),
      $sampled(exp_moved)));

  a_reset: assert property (@(posedge i_clk) disable iff (!i_rst_n)
    chk_rst |-> (o_empty && !o_full && !o_overrun && !o_underrun && o_moved == '0))
    else log_failure("outputs not in their reset state after reset");

  a_overrun_set: assert property (@(posedge i_clk) disable iff (!i_rst_n)
    drop_enq |=> o_overrun)
    else log_failure("o_overrun did not set after an enqueue at full depth");

  a_overrun_quiet: assert property (@(posedge i_clk) disable iff (!i_rst_n)
    (!o_overrun && !drop_enq) |=> !o_overrun)
    else log_failure("o_overrun set although no enqueue hit full depth");

  a_overrun_sticky: assert property (@(posedge i_clk) disable iff (!i_rst_n)
    (o_overrun && !i_clr_err) |=> o_overrun)
    else log_failure("o_overrun cleared without i_clr_err");

  a_underrun_set: assert property (@(posedge i_clk) disable iff (!i_rst_n)
    (i_read && o_empty) |=> o_underrun)
    else log_failure("o_underrun did not set after a read while empty");

  a_underrun_quiet: assert property (@(posedge i_clk) disable iff (!i_rst_n)
    (!o_underrun && !(i_read && o_empty)) |=> !o_underrun)
    else log_failure("o_underrun set although no read hit an empty FIFO");

  a_underrun_sticky: assert property (@(posedge i_clk) disable iff (!i_rst_n)
    (o_underrun && !i_clr_err) |=> o_underrun)
    else log_failure("o_underrun cleared without i_clr_err");

  a_clear: assert property (@(posedge i_clk) disable iff (!i_rst_n)
    i_clr_err |=> (!o_overrun && !o_underrun))
    else log_failure("i_clr_err left an error flag set");

  function automatic word_t rand_word();
    word_t w;
    for (int i = 0; i < WORD_W / 32; i++) begin
      w[i*32 +: 32] = $random(seed);
    end
    return w;
  endfunction

  // step to just after the next edge, strobes back to idle
  task automatic next_cycle();
    @(posedge i_clk);
    #DRIVE_DLY;
    i_enq     = 1'b0;
    i_read    = 1'b0;
    i_clr_err = 1'b0;
    chk_item  = 1'b0;
    chk_lvl   = 1'b0;
    chk_moved = 1'b0;
    chk_rst   = 1'b0;
    drop_enq  = 1'b0;
  endtask

  task automatic idle(input int n);
    repeat (n) next_cycle();
  endtask

  // upstream honours o_full, downstream honours o_empty
  task automatic drive_cycle(input logic want_enq, input logic want_read);
    word_t w;
    next_cycle();
    if (want_enq && !o_full) begin
      w = rand_word();
      i_enq  = 1'b1;
      i_data = w;
      model_q.push_back(w);
      pushed++;
    end
    if (want_read && !o_empty) begin
      i_read = 1'b1;
      if (model_q.size() == 0) begin
        log_failure("output FIFO shows a word that was never enqueued");
      end else begin
        chk_item = 1'b1;
        exp_item = model_q.pop_front();
      end
    end
  endtask

  // enqueue regardless of o_full
  task automatic push_word(input logic expect_drop);
    word_t w;
    next_cycle();
    w = rand_word();
    i_enq  = 1'b1;
    i_data = w;
    if (expect_drop) begin
      drop_enq = 1'b1;
    end else begin
      model_q.push_back(w);
      pushed++;
    end
  endtask

  task automatic drain();
    while (model_q.size() != 0) begin
      drive_cycle(1'b0, 1'b1);
    end
    idle(2);
    next_cycle();
    chk_moved = 1'b1;
    exp_moved = move_cnt_t'(pushed); // chain empty, so all accepted words were moved
    idle(1);
  endtask

  task automatic finish_test(input string name);
    idle(2);
    if (err_cnt == test_err_base) begin
      pass_cnt++;
      $display("[%0t ns] %s: ok", $time, name);
    end else begin
      fail_cnt++;
      $display("[%0t ns] %s: %0d errors", $time, name, err_cnt - test_err_base);
    end
    test_err_base = err_cnt;
  endtask

  initial begin
    int in_srl;
    i_rst_n   = 1'b0;
    i_clr_err = 1'b0;
    i_enq     = 1'b0;
    i_data    = '0;
    i_read    = 1'b0;
    chk_item  = 1'b0;
    exp_item  = '0;
    chk_lvl   = 1'b0;
    exp_avail = 1'b0;
    exp_full  = 1'b0;
    chk_moved = 1'b0;
    exp_moved = '0;
    chk_rst   = 1'b0;
    drop_enq  = 1'b0;
    pushed        = 0;
    err_cnt       = 0;
    test_err_base = 0;
    pass_cnt      = 0;
    fail_cnt      = 0;

    repeat (RST_CYCLES) @(posedge i_clk);
    #DRIVE_DLY;
    i_rst_n = 1'b1;
    chk_rst = 1'b1; // first edge out of reset
    finish_test("reset state");

    for (int c = 0; c < RAND_CYCLES; c++) begin
      drive_cycle(($random(seed) & 1) != 0, ($random(seed) & 1) != 0);
    end
    drain();
    finish_test("order and data");

    // reads stopped, one word at a time so the chain settles
    for (int k = 0; k <= LVL_WORDS; k++) begin
      if (k > 0) begin
        push_word(1'b0);
      end
      idle(3);
      next_cycle();
      in_srl    = (k > RING_DEPTH + 1) ? k - RING_DEPTH - 1 : 0;
      chk_lvl   = 1'b1;
      exp_avail = (in_srl <= int'(SRL_AVAIL_LEVEL));
      exp_full  = (in_srl >= int'(SRL_FULL_LEVEL));
    end
    finish_test("fill levels");

    repeat (10) drive_cycle(1'b1, 1'b0); // held off by o_full
    for (int c = 0; c < BP_CYCLES; c++) begin
      drive_cycle(($random(seed) & 3) != 0, ($random(seed) & 1) != 0);
    end
    drain();
    finish_test("back-pressure");

    repeat (CHAIN_CAP) push_word(1'b0); // input FIFO ends at full depth
    idle(4);
    push_word(1'b1);
    idle(3);
    next_cycle();
    i_clr_err = 1'b1;
    idle(2);
    drain();
    finish_test("overrun");

    next_cycle();
    if (!o_empty) begin
      log_failure("output FIFO not empty before the underrun read");
    end
    i_read = 1'b1;  // o_item ignored here
    idle(3);
    drive_cycle(1'b1, 1'b0);
    drain();
    next_cycle();
    i_clr_err = 1'b1;
    idle(2);
    finish_test("underrun");

    $display("tests passed: %0d  failed: %0d  errors: %0d", pass_cnt, fail_cnt, err_cnt);
    if (fail_cnt == 0 && err_cnt == 0) begin
      $display("Simulation finished: PASS");
    end else begin
      $display("Simulation finished: FAIL");
    end
    $finish;
  end

endmodule
